// File: files.f
logic/clock_ctrl_pkg.sv
logic/global_reset_gen.sv
logic/clock_activity_mon.sv
logic/dps_phaser.sv
logic/clock_ctrl.sv
tb/clock_ctrl_tb.sv

// File: logic/clock_activity_mon.sv
`timescale 1ns/1ps
`default_nettype none

//----------------------------------------------------------
// Activity monitor for auxiliary clock inputs
//----------------------------------------------------------
module clock_activity_mon (
	input  wire  clock,									// Main 40 MHz clock
	input  wire  arst_n,								// Async active low reset
	input  wire  [clock_ctrl_pkg::N_MON-1:0] aux_clk,	// Clocks to watch
	output logic [clock_ctrl_pkg::N_MON-1:0] aux_active	// Input is toggling
);
	import clock_ctrl_pkg::*;

	//----------------------------------------------------------
	// Declarations
	//----------------------------------------------------------
	logic [N_MON-1:0] rise_q;	// Sampled on rising edge
	logic [N_MON-1:0] fall_q;	// Sampled on falling edge

	//----------------------------------------------------------
	// Dual edge sampling
	//----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			rise_q <= '0;
		else
			rise_q <= aux_clk;
	end

	always_ff @(negedge clock or negedge arst_n) begin
		if (!arst_n)
			fall_q <= '0;
		else
			fall_q <= aux_clk;
	end

	//----------------------------------------------------------
	// Activity flags
	//----------------------------------------------------------
	// Samples differ when the input moved between edges
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			aux_active <= '0;
		else
			aux_active <= rise_q ^ fall_q;	// Stuck input gives 0
	end

endmodule

`default_nettype wire

// File: logic/clock_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

//----------------------------------------------------------
// Clock controller logic top level
//----------------------------------------------------------
module clock_ctrl (
	// Clock and reset
	input  wire  clock,				// Main 40 MHz clock
	input  wire  arst_n,			// Async reset, active low

	// Global reset
	input  wire  main_lock,			// Main PLL lock
	input  wire  global_reset_en,	// Re-fire reset on lock loss
	output logic global_reset,		// Held until main PLL locks
	output logic lock_lost_err,		// Main lock lost after startup

	// Phaser channels
	input  wire clock_ctrl_pkg::dps_ctrl_t ctrl [clock_ctrl_pkg::N_DPS],	// Per channel request
	output clock_ctrl_pkg::dps_stat_t      stat [clock_ctrl_pkg::N_DPS],	// Per channel status
	output clock_ctrl_pkg::ps_req_t        ps   [clock_ctrl_pkg::N_DPS],	// Step requests
	input  wire  [clock_ctrl_pkg::N_DPS-1:0] ps_done,	// Step finished
	input  wire  [clock_ctrl_pkg::N_DPS-1:0] dps_lock,	// Channel PLL locks

	// Auxiliary clock monitor
	input  wire  [clock_ctrl_pkg::N_MON-1:0] aux_clk,	// 40 MHz inputs to watch
	output logic [clock_ctrl_pkg::N_MON-1:0] aux_active	// Input is toggling
);
	import clock_ctrl_pkg::*;

	//----------------------------------------------------------
	// Global reset
	//----------------------------------------------------------
	global_reset_gen i_global_reset_gen (
		.clock           (clock),
		.arst_n          (arst_n),
		.main_lock       (main_lock),
		.global_reset_en (global_reset_en),
		.global_reset    (global_reset),
		.lock_lost_err   (lock_lost_err)
	);

	//----------------------------------------------------------
	// Phase shifter channels
	//----------------------------------------------------------
	// 2 ALCT plus 2 DCFEB groups
	for (genvar i = 0; i < N_DPS; i++) begin : g_dps
		dps_phaser i_dps_phaser (
			.clock        (clock),
			.arst_n       (arst_n),
			.global_reset (global_reset),	// Shared by all channels
			.main_lock    (main_lock),
			.dps_lock     (dps_lock[i]),
			.ctrl         (ctrl[i]),
			.ps_done      (ps_done[i]),
			.stat         (stat[i]),
			.ps           (ps[i])
		);
	end

	//----------------------------------------------------------
	// Auxiliary clock activity
	//----------------------------------------------------------
	clock_activity_mon i_clock_activity_mon (
		.clock      (clock),
		.arst_n     (arst_n),
		.aux_clk    (aux_clk),
		.aux_active (aux_active)
	);

endmodule

`default_nettype wire

// File: logic/clock_ctrl_pkg.sv
`default_nettype none

//----------------------------------------------------------
// Shared constants and types for the clock controller
//----------------------------------------------------------
package clock_ctrl_pkg;

	//----------------------------------------------------------
	// Sizes
	//----------------------------------------------------------
	localparam int N_DPS = 4;	// Phase shifter channels
	localparam int N_MON = 7;	// Auxiliary 40 MHz inputs watched

	// One 25 ns cycle in code units and in fine steps
	localparam int CODES_PER_CYCLE = 256;	// VME phase code resolution
	localparam int STEPS_PER_CYCLE = 1400;	// Fine steps per clock period

	localparam int CODE_W = $clog2(CODES_PER_CYCLE);	// 8 bit phase code
	localparam int STEP_W = 11;	// Holds 0 to 1399

	//----------------------------------------------------------
	// Phaser state machine
	//----------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE       = 3'd0,	// Waiting for fire
		WAIT_LOCK  = 3'd1,	// Hold off until all locks good
		CALC       = 3'd2,	// Compare target and position
		STEP       = 3'd3,	// One cycle psen pulse
		WAIT_DONE  = 3'd4,	// Wait for shifter done
		HOLD_RESET = 3'd5	// Channel shifter held in reset
	} phaser_state_e;

	//----------------------------------------------------------
	// Channel control from the register side
	//----------------------------------------------------------
	typedef struct packed {
		logic              fire;		// One cycle new phase request
		logic              chan_reset;	// Reset this channel's shifter
		logic [CODE_W-1:0] code;		// Phase to set, 0-255
	} dps_ctrl_t;

	// Channel status back to the register side
	typedef struct packed {
		logic          busy;	// Move in progress
		phaser_state_e state;	// Current FSM state
	} dps_stat_t;

	// Request to the phase shifter port
	typedef struct packed {
		logic psen;		// Step enable, one cycle
		logic psincdec;	// 1 increments, 0 decrements
	} ps_req_t;

endpackage

`default_nettype wire

// File: logic/dps_phaser.sv
`timescale 1ns/1ps
`default_nettype none

//----------------------------------------------------------
// One digital phase shifter channel
//----------------------------------------------------------
module dps_phaser (
	input  wire                       clock,		// Main 40 MHz clock
	input  wire                       arst_n,		// Async active low reset
	input  wire                       global_reset,	// Held until main PLL locks
	input  wire                       main_lock,	// Main PLL lock
	input  wire                       dps_lock,		// This channel's PLL lock
	input  wire clock_ctrl_pkg::dps_ctrl_t ctrl,	// Fire, channel reset, code
	input  wire                       ps_done,		// Step finished
	output clock_ctrl_pkg::dps_stat_t stat,			// Busy and state
	output clock_ctrl_pkg::ps_req_t   ps			// Step request
);
	import clock_ctrl_pkg::*;

	//----------------------------------------------------------
	// Declarations
	//----------------------------------------------------------
	phaser_state_e state_q;		// Current state
	phaser_state_e state_d;		// Next state

	logic [STEP_W-1:0]        pos_q;		// Shifter position in fine steps
	logic [STEP_W-1:0]        target_q;		// Position wanted by last fire
	logic                     up_q;			// Direction of the pending step
	logic [CODE_W+STEP_W-1:0] scaled;		// code*1400 + half a code step
	logic [STEP_W-1:0]        target_calc;	// Rounded fine-step target
	logic                     locked;		// Safe to step
	logic                     fire_ok;		// Fire accepted this cycle
	logic                     step_done;	// Done seen while waiting

	//----------------------------------------------------------
	// Code to fine-step conversion
	//----------------------------------------------------------
	// Scale by 1400/256 with round to nearest through the added 128
	assign scaled = (CODE_W+STEP_W)'(ctrl.code) * (CODE_W+STEP_W)'(STEPS_PER_CYCLE)
		+ (CODE_W+STEP_W)'(CODES_PER_CYCLE / 2);

	// Divide by 256
	assign target_calc = scaled[CODE_W+STEP_W-1:CODE_W];

	//----------------------------------------------------------
	// Qualifiers
	//----------------------------------------------------------
	assign locked    = !global_reset && main_lock && dps_lock;	// All clocks good
	assign fire_ok   = (state_q == IDLE) && ctrl.fire;			// Ignored when busy
	assign step_done = (state_q == WAIT_DONE) && ps_done;		// Position moves now

	//----------------------------------------------------------
	// Next state
	//----------------------------------------------------------
	always_comb begin
		state_d = state_q;

		case (state_q)
			IDLE: begin
				if (ctrl.fire)
					state_d = WAIT_LOCK;	// New phase requested
			end

			WAIT_LOCK: begin
				if (locked)
					state_d = CALC;
			end

			CALC: begin
				if (target_q == pos_q)
					state_d = IDLE;			// Arrived
				else
					state_d = STEP;
			end

			STEP: begin
				state_d = WAIT_DONE;		// psen is high for this one cycle
			end

			WAIT_DONE: begin
				if (ps_done)
					state_d = WAIT_LOCK;	// Recheck locks before next step
			end

			HOLD_RESET: begin
				state_d = IDLE;				// Leaves once chan_reset drops
			end

			default: begin
				state_d = IDLE;
			end
		endcase

		// Channel reset wins over everything
		if (ctrl.chan_reset)
			state_d = HOLD_RESET;
	end

	//----------------------------------------------------------
	// State and position
	//----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= IDLE;
			pos_q   <= '0;
		end else begin
			state_q <= state_d;

			if (ctrl.chan_reset) begin
				pos_q <= '0;				// Shifter back to zero phase
			end else if (step_done) begin
				if (up_q)
					pos_q <= pos_q + 1'b1;	// One fine step later
				else
					pos_q <= pos_q - 1'b1;	// One fine step earlier
			end
		end
	end

	//----------------------------------------------------------
	// Target and direction
	//----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			target_q <= '0;
			up_q     <= 1'b0;
		end else begin
			if (fire_ok)
				target_q <= target_calc;		// Latch at fire

			if (state_q == CALC)
				up_q <= (target_q > pos_q);		// Chosen before each step
		end
	end

	//----------------------------------------------------------
	// Outputs
	//----------------------------------------------------------
	assign ps.psen     = (state_q == STEP);	// Exactly one cycle per step
	assign ps.psincdec = up_q;				// Valid with psen

	// Busy covers everything between fire and arrival
	assign stat.busy  = (state_q != IDLE) && (state_q != HOLD_RESET);
	assign stat.state = state_q;

endmodule

`default_nettype wire

// File: logic/global_reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

//----------------------------------------------------------
// Global reset from main PLL lock
//----------------------------------------------------------
module global_reset_gen (
	input  wire  clock,				// Main 40 MHz clock
	input  wire  arst_n,			// Async reset, active low
	input  wire  main_lock,			// Main PLL lock
	input  wire  global_reset_en,	// Re-fire reset on lock loss
	output logic global_reset,		// Held until first lock
	output logic lock_lost_err		// Lock dropped after startup
);

	//----------------------------------------------------------
	// Declarations
	//----------------------------------------------------------
	logic startup_done;		// Set once main PLL has locked
	logic first_lock;		// Lock now or seen before

	assign first_lock = main_lock || startup_done;

	//----------------------------------------------------------
	// Startup latch and reset flop
	//----------------------------------------------------------
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			startup_done <= 1'b0;
			global_reset <= 1'b1;	// Held from power up
		end else begin
			startup_done <= first_lock;	// Sticks after first lock
			// Released after first lock, optionally re-fires on loss
			global_reset <= !first_lock || (!main_lock && global_reset_en);
		end
	end

	//----------------------------------------------------------
	// Lock lost flag
	//----------------------------------------------------------
	// Only meaningful once out of reset
	assign lock_lost_err = !global_reset && !main_lock;

endmodule

`default_nettype wire

// File: tb/clock_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_tb;
	import clock_ctrl_pkg::*;

	//----------------------------------------------------------
	// Constants and stimulus table
	//----------------------------------------------------------
	localparam int N_ROWS = 10;
	localparam logic [1:0] ACT_PLAIN  = 2'd0;	// Fire and wait
	localparam logic [1:0] ACT_REFIRE = 2'd1;	// Second fire while busy
	localparam logic [1:0] ACT_NOLOCK = 2'd2;	// Channel lock low at fire
	localparam logic [N_MON-1:0] AUX_INIT = 7'b0100100;	// Stuck levels
	localparam logic [N_MON-1:0] AUX_MASK = 7'b0001001;	// Bits that toggle

	typedef struct packed {
		logic [1:0]        chan;
		logic [CODE_W-1:0] code;
		logic              chan_reset;	// Pulse channel reset first
		logic [1:0]        action;
		logic [STEP_W-1:0] exp_pos;		// Fine steps after the move
	} row_t;

	row_t table_rows [N_ROWS];

	//----------------------------------------------------------
	// DUT signals
	//----------------------------------------------------------
	logic             clock;
	logic             arst_n;
	logic             main_lock;
	logic             global_reset_en;
	dps_ctrl_t        ctrl [N_DPS];
	dps_stat_t        stat [N_DPS];
	ps_req_t          ps [N_DPS];
	logic [N_DPS-1:0] ps_done = '0;		// Driven by the port model
	logic [N_DPS-1:0] dps_lock;
	logic [N_MON-1:0] aux_clk = AUX_INIT;
	logic [N_MON-1:0] aux_active;
	logic             global_reset;
	logic             lock_lost_err;
	logic             aux_toggle;

	// Port model state
	logic [31:0] rand_state;
	int          done_cnt [N_DPS];		// Cycles until done
	int          inc_cnt [N_DPS];		// Increment pulses seen
	int          dec_cnt [N_DPS];		// Decrement pulses seen
	int          model_pos [N_DPS];		// Signed shifter position
	int          step_errors;

	// Checker state
	int          prev_pos [N_DPS];		// Expected position before move
	int          start_inc [N_DPS];
	int          start_dec [N_DPS];
	int          mismatches;
	int          failures;

	clock_ctrl i_clock_ctrl (
		.clock           (clock),
		.arst_n          (arst_n),
		.main_lock       (main_lock),
		.global_reset_en (global_reset_en),
		.global_reset    (global_reset),
		.lock_lost_err   (lock_lost_err),
		.ctrl            (ctrl),
		.stat            (stat),
		.ps              (ps),
		.ps_done         (ps_done),
		.dps_lock        (dps_lock),
		.aux_clk         (aux_clk),
		.aux_active      (aux_active)
	);

	always #4 clock = ~clock;	// 8 ns period

	//----------------------------------------------------------
	// Helpers
	//----------------------------------------------------------
	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;	// Plain LCG
	endfunction

	task report_mismatch(input string name, input int expected, input int actual);
		mismatches++;
		$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
	endtask

	task load_table();
		//              chan  code    rst   action      exp_pos
		table_rows[0] = {2'd0, 8'd10, 1'b0, ACT_PLAIN,  11'd55};
		table_rows[1] = {2'd0, 8'd37, 1'b0, ACT_REFIRE, 11'd202};
		table_rows[2] = {2'd0, 8'd20, 1'b0, ACT_PLAIN,  11'd109};	// Down 93
		table_rows[3] = {2'd1, 8'd25, 1'b0, ACT_PLAIN,  11'd137};
		table_rows[4] = {2'd1, 8'd12, 1'b0, ACT_NOLOCK, 11'd66};
		table_rows[5] = {2'd1, 8'd3,  1'b1, ACT_PLAIN,  11'd16};	// From 0 again
		table_rows[6] = {2'd0, 8'd20, 1'b0, ACT_PLAIN,  11'd109};	// No steps
		table_rows[7] = {2'd2, 8'd40, 1'b0, ACT_NOLOCK, 11'd219};
		table_rows[8] = {2'd3, 8'd5,  1'b1, ACT_PLAIN,  11'd27};
		table_rows[9] = {2'd0, 8'd0,  1'b0, ACT_PLAIN,  11'd0};
	endtask

	task check_startup_quiet(input logic exp_greset);
		if (global_reset !== exp_greset)
			report_mismatch("global_reset", exp_greset, global_reset);
		for (int i = 0; i < N_DPS; i++) begin
			if (stat[i].busy !== 1'b0)
				report_mismatch($sformatf("stat[%0d].busy", i), 0, stat[i].busy);
			if (ps[i].psen !== 1'b0)
				report_mismatch($sformatf("ps[%0d].psen", i), 0, ps[i].psen);
		end
	endtask

	task pulse_chan_reset(input int ch);
		@(posedge clock);
		ctrl[ch].chan_reset <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		if (stat[ch].state !== HOLD_RESET)
			report_mismatch($sformatf("stat[%0d].state", ch), HOLD_RESET, stat[ch].state);
		if (stat[ch].busy !== 1'b0)
			report_mismatch($sformatf("stat[%0d].busy", ch), 0, stat[ch].busy);
		@(posedge clock);
		ctrl[ch].chan_reset <= 1'b0;
		@(posedge clock);	// Channel back in IDLE
		prev_pos[ch] = 0;
	endtask

	task fire_channel(input int ch, input logic [CODE_W-1:0] code);
		@(posedge clock);
		ctrl[ch].fire <= 1'b1;
		ctrl[ch].code <= code;
		@(posedge clock);
		ctrl[ch].fire <= 1'b0;
		@(negedge clock);
		if (stat[ch].busy !== 1'b1)
			report_mismatch($sformatf("stat[%0d].busy", ch), 1, stat[ch].busy);
	endtask

	task wait_idle(input int ch);
		while (stat[ch].busy !== 1'b0)
			@(negedge clock);
	endtask

	task mark_start(input int ch);
		start_inc[ch] = inc_cnt[ch];
		start_dec[ch] = dec_cnt[ch];
	endtask

	// Pulse counts follow from the distance between old and new target
	task check_move(input int ch, input int exp_pos);
		int exp_inc;
		int exp_dec;
		exp_inc = (exp_pos > prev_pos[ch]) ? exp_pos - prev_pos[ch] : 0;
		exp_dec = (exp_pos < prev_pos[ch]) ? prev_pos[ch] - exp_pos : 0;
		if (inc_cnt[ch] - start_inc[ch] != exp_inc)
			report_mismatch($sformatf("ps[%0d] increments", ch), exp_inc,
				inc_cnt[ch] - start_inc[ch]);
		if (dec_cnt[ch] - start_dec[ch] != exp_dec)
			report_mismatch($sformatf("ps[%0d] decrements", ch), exp_dec,
				dec_cnt[ch] - start_dec[ch]);
		if (model_pos[ch] != exp_pos)
			report_mismatch($sformatf("position[%0d]", ch), exp_pos, model_pos[ch]);
		prev_pos[ch] = exp_pos;
	endtask

	task run_row(input int r);
		row_t row;
		int   ch;
		row = table_rows[r];
		ch  = int'(row.chan);
		if (row.chan_reset)
			pulse_chan_reset(ch);
		mark_start(ch);
		if (row.action == ACT_NOLOCK) begin
			@(posedge clock);
			dps_lock[ch] <= 1'b0;	// Channel PLL not locked yet
		end
		fire_channel(ch, row.code);
		if (row.action == ACT_REFIRE) begin
			repeat (3) @(posedge clock);
			ctrl[ch].fire <= 1'b1;
			ctrl[ch].code <= row.code ^ 8'h5a;	// Other phase, must be dropped
			@(posedge clock);
			ctrl[ch].fire <= 1'b0;
		end
		if (row.action == ACT_NOLOCK) begin
			repeat (20) @(negedge clock);
			if (inc_cnt[ch] + dec_cnt[ch] != start_inc[ch] + start_dec[ch]) begin
				failures++;
				$display("Channel %0d stepped while its lock was low", ch);
			end
			if (stat[ch].busy !== 1'b1)
				report_mismatch($sformatf("stat[%0d].busy", ch), 1, stat[ch].busy);
			@(posedge clock);
			dps_lock[ch] <= 1'b1;
		end
		@(negedge clock);
		wait_idle(ch);
		check_move(ch, int'(row.exp_pos));
	endtask

	//----------------------------------------------------------
	// Phase shifter port model
	//----------------------------------------------------------
	always @(posedge clock) begin
		if (!arst_n) begin
			rand_state = 32'h4b2e;
			step_errors = 0;
			for (int i = 0; i < N_DPS; i++) begin
				done_cnt[i]  = 0;
				inc_cnt[i]   = 0;
				dec_cnt[i]   = 0;
				model_pos[i] = 0;
			end
			ps_done <= '0;
		end else begin
			for (int i = 0; i < N_DPS; i++) begin
				ps_done[i] <= 1'b0;
				if (ctrl[i].chan_reset)
					model_pos[i] = 0;	// Shifter back to zero
				if (done_cnt[i] != 0) begin
					done_cnt[i] = done_cnt[i] - 1;
					if (done_cnt[i] == 0)
						ps_done[i] <= 1'b1;	// One cycle done
				end
				if (ps[i].psen) begin
					if (done_cnt[i] != 0) begin
						step_errors++;
						$display("Channel %0d stepped again before done at %0t", i, $time);
					end
					if (global_reset || !main_lock || !dps_lock[i]) begin
						step_errors++;
						$display("Channel %0d stepped without lock at %0t", i, $time);
					end
					rand_state  = next_random(rand_state);
					done_cnt[i] = 1 + int'(rand_state[17:16]);	// 1 to 4 cycles
					if (ps[i].psincdec) begin
						inc_cnt[i]++;
						model_pos[i]++;
					end else begin
						dec_cnt[i]++;
						model_pos[i]--;
					end
				end
			end
		end
	end

	always @(posedge clock) begin
		if (aux_toggle)
			aux_clk <= aux_clk ^ AUX_MASK;
	end

	// Watchdog
	initial begin
		repeat (N_ROWS * 2000) @(posedge clock);
		$display("Timeout after %0d cycles, a phase move never finished", N_ROWS * 2000);
		$display("Checks failed");
		$finish;
	end

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial begin
		clock           = 1'b0;
		arst_n          = 1'b0;
		main_lock       = 1'b0;
		global_reset_en = 1'b0;
		dps_lock        = '1;
		aux_toggle      = 1'b0;
		mismatches      = 0;
		failures        = 0;
		for (int i = 0; i < N_DPS; i++) begin
			ctrl[i]     = '0;
			prev_pos[i] = 0;
		end
		load_table();

		// Startup reset, PLL not locked
		repeat (15) @(posedge clock);
		@(negedge clock);
		check_startup_quiet(1'b1);
		@(posedge clock);
		arst_n <= 1'b1;
		repeat (10) begin
			@(negedge clock);
			check_startup_quiet(1'b1);
		end
		@(posedge clock);
		main_lock <= 1'b1;
		@(negedge clock);
		check_startup_quiet(1'b1);		// Flop not yet released
		@(negedge clock);
		check_startup_quiet(1'b0);

		// Table driven phase moves
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);

		// Two channels moving together
		mark_start(2);
		mark_start(3);
		@(posedge clock);
		ctrl[2].fire <= 1'b1;
		ctrl[2].code <= 8'd12;	// 219 down to 66
		ctrl[3].fire <= 1'b1;
		ctrl[3].code <= 8'd25;	// 27 up to 137
		@(posedge clock);
		ctrl[2].fire <= 1'b0;
		ctrl[3].fire <= 1'b0;
		@(negedge clock);
		if (stat[2].busy !== 1'b1)
			report_mismatch("stat[2].busy", 1, stat[2].busy);
		if (stat[3].busy !== 1'b1)
			report_mismatch("stat[3].busy", 1, stat[3].busy);
		wait_idle(2);
		wait_idle(3);
		check_move(2, 66);
		check_move(3, 137);

		// Lock loss with reset re-fire
		@(posedge clock);
		global_reset_en <= 1'b1;
		main_lock       <= 1'b0;
		@(negedge clock);
		if (lock_lost_err !== 1'b1)
			report_mismatch("lock_lost_err", 1, lock_lost_err);
		@(negedge clock);
		if (global_reset !== 1'b1)
			report_mismatch("global_reset", 1, global_reset);
		@(posedge clock);
		main_lock       <= 1'b1;
		global_reset_en <= 1'b0;
		repeat (2) @(negedge clock);
		if (global_reset !== 1'b0)
			report_mismatch("global_reset", 0, global_reset);

		// Lock loss flagged only
		@(posedge clock);
		main_lock <= 1'b0;
		repeat (3) @(negedge clock);
		if (lock_lost_err !== 1'b1)
			report_mismatch("lock_lost_err", 1, lock_lost_err);
		if (global_reset !== 1'b0)
			report_mismatch("global_reset", 0, global_reset);
		@(posedge clock);
		main_lock <= 1'b1;
		@(negedge clock);
		if (lock_lost_err !== 1'b0)
			report_mismatch("lock_lost_err", 0, lock_lost_err);

		// Aux clock activity
		if (aux_active !== '0)
			report_mismatch("aux_active", 0, aux_active);
		@(posedge clock);
		aux_toggle <= 1'b1;
		repeat (6) @(negedge clock);
		if (aux_active !== AUX_MASK)
			report_mismatch("aux_active", AUX_MASK, aux_active);

		repeat (4) @(posedge clock);
		$display("Errors: %0d value mismatches, %0d protocol errors", mismatches,
			failures + step_errors);
		if (mismatches == 0 && failures == 0 && step_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
